//--- mems_bridge.f
src/mems_pkg.sv
src/uart_rx.sv
src/cmd_assembler.sv
src/word_fifo.sv
src/mems_spi_master.sv
src/mems_bridge_top.sv
testbench/mems_bridge_sva.sv
testbench/mems_bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mems_bridge_tb
FILELIST  := mems_bridge.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/mems_bridge_tb.sv
`timescale 1ns/1ps

module mems_bridge_tb;

  localparam int baud_div    = 16;
  localparam int fifo_depth  = 4;
  localparam int clk_div     = 6;
  localparam int sck_period  = 1 << clk_div;          // Clocks per sck period
  localparam int quiet_len   = 4 * sck_period;        // cs high this long, queue drained
  localparam int n_writes    = 4;
  localparam int n_reads     = 4;
  localparam int n_burst     = 10;
  localparam int word_cycles = 30 * baud_div + 26 * sck_period;
  localparam int cycle_limit = (n_writes + n_reads + n_burst + 1) * word_cycles + 10000;

  logic        clk;
  logic        rst;
  logic        rx;
  logic        miso;
  logic        sck;
  logic        mosi;
  logic        cs;
  logic [15:0] rd_data;
  logic        rd_valid;
  logic        overflow;

  logic [23:0] frames_q[$];     // MOSI word of each finished frame
  logic [23:0] used_resp_q[$];  // MISO word driven in each frame
  logic [23:0] resp_q[$];       // Responses for the coming frames
  logic [15:0] rd_q[$];         // rd_data taken with rd_valid
  logic [23:0] frame;
  logic [23:0] cur_resp;
  int          nbits;
  int          miso_idx;
  bit          in_frame;
  string       cur_test;
  int          errors;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;
  int          cycle_cnt;
  int unsigned seed_ret;

  mems_bridge_top #(
    .BAUD_DIV   (baud_div),
    .FIFO_DEPTH (fifo_depth),
    .CLK_DIV    (clk_div)
  ) mems_bridge_top_inst (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .sck      (sck),
    .mosi     (mosi),
    .miso     (miso),
    .cs       (cs),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .overflow (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Sensor model, frame start
  always @(negedge cs) begin
    in_frame = 1'b1;
    nbits    = 0;
    frame    = '0;
    #2;
    if (resp_q.size() > 0)
      cur_resp = resp_q.pop_front();
    else
      cur_resp = '0;
    used_resp_q.push_back(cur_resp);
    miso     = cur_resp[23];  // MSB before the first rising edge
    miso_idx = 22;
  end

  always @(posedge sck) begin
    if (!cs) begin
      frame = {frame[22:0], mosi};  // Sensor samples on the rise
      nbits++;
    end
  end

  always @(negedge sck) begin
    #2;
    if (!cs && miso_idx >= 0) begin
      miso = cur_resp[miso_idx];
      miso_idx--;
    end
  end

  always @(posedge cs) begin
    if (in_frame) begin
      in_frame = 1'b0;
      assert (nbits == 24) else begin
        $display("[ERROR] %s: sck rises per frame expected 24, got %0d", cur_test, nbits);
        errors++;
      end
      frames_q.push_back(frame);
    end
  end

  always @(posedge clk) begin
    if (!rst && rd_valid)
      rd_q.push_back(rd_data);
  end

  // Cycle counter guard
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  task automatic drive_bit(input logic b);
    @(posedge clk);
    #2;
    rx = b;
    repeat (baud_div - 1) @(posedge clk);
  endtask

  // 8N1, LSB first
  task automatic send_byte(input logic [7:0] b, input bit bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++)
      drive_bit(b[i]);
    drive_bit(!bad_stop);
    if (bad_stop)
      drive_bit(1'b1);  // Line back to idle
  endtask

  task automatic send_word(input logic [23:0] w);
    send_byte(w[23:16], 1'b0);
    send_byte(w[15:8], 1'b0);
    send_byte(w[7:0], 1'b0);
  endtask

  function automatic logic [23:0] rand_word(input mems_pkg::mems_op_e op);
    mems_pkg::mems_cmd_t c;
    c.op   = op;
    c.addr = 7'($urandom());
    c.data = 16'($urandom());
    return c;
  endfunction

  task automatic check_val(input string what, input logic [23:0] exp, input logic [23:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: %s expected %h, got %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    assert (act == exp) else begin
      $display("[ERROR] %s: %s expected %0d, got %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic clear_capture();
    frames_q.delete();
    used_resp_q.delete();
    resp_q.delete();
    rd_q.delete();
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    clear_capture();
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_err_start) begin
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  task automatic wait_frames(input int n);
    int waited;
    waited = 0;
    while (frames_q.size() < n && waited < 4 * word_cycles) begin
      @(posedge clk);
      waited++;
    end
    assert (frames_q.size() >= n) else begin
      $display("%s: no cs frame finished within %0d cycles", cur_test, waited);
      errors++;
    end
  endtask

  // Returns once cs has stayed high for quiet_len clocks
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < quiet_len) begin
      @(posedge clk);
      if (cs)
        quiet++;
      else
        quiet = 0;
    end
  endtask

  // One word with the queue idle, bit 23 set means a read
  task automatic run_single(input logic [23:0] w);
    logic [23:0] resp;
    resp = 24'($urandom());
    resp_q.push_back(resp);
    send_word(w);
    wait_frames(1);
    wait_quiet();
    check_count("frame count", 1, frames_q.size());
    if (frames_q.size() > 0)
      check_val("frame", w, frames_q[0]);
    check_count("rd_valid pulses", w[23] ? 1 : 0, rd_q.size());
    if (w[23] && rd_q.size() > 0)
      check_val("rd_data", {8'h00, resp[15:0]}, {8'h00, rd_q[0]});
  endtask

  initial begin
    logic [23:0] burst [n_burst];
    int          i;
    int          j;
    int          k;
    int          n;
    int          n_rd;
    seed_ret = $urandom(32'h18d7_37d6);
    rst          = 1'b1;
    rx           = 1'b1;
    miso         = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("reset_state");
    check_val("cs", 24'h1, {23'h0, cs});
    check_val("sck", 24'h0, {23'h0, sck});
    check_val("rd_valid", 24'h0, {23'h0, rd_valid});
    check_val("overflow", 24'h0, {23'h0, overflow});
    end_test();

    start_test("write_cmds");
    for (i = 0; i < n_writes; i++) begin
      clear_capture();
      run_single(rand_word(mems_pkg::op_write));
    end
    end_test();

    start_test("read_cmds");
    for (i = 0; i < n_reads; i++) begin
      clear_capture();
      run_single(rand_word(mems_pkg::op_read));
    end
    end_test();

    // Producer outruns the SPI side, drops allowed but flagged
    start_test("burst_order");
    for (i = 0; i < n_burst; i++) begin
      burst[i] = rand_word((($urandom() & 1) != 0) ? mems_pkg::op_read : mems_pkg::op_write);
      resp_q.push_back(24'($urandom()));
    end
    for (i = 0; i < n_burst; i++)
      send_word(burst[i]);
    wait_quiet();
    n = frames_q.size();
    assert (n >= 1 && n <= n_burst) else begin
      $display("[ERROR] %s: frame count expected 1 to %0d, got %0d", cur_test, n_burst, n);
      errors++;
    end
    if (n >= 1)
      check_val("first frame", burst[0], frames_q[0]);
    j = 0;
    for (i = 0; i < n; i++) begin
      while (j < n_burst && burst[j] != frames_q[i])
        j++;
      assert (j < n_burst) else begin
        $display("%s: frame %0d (%h) is out of order or never sent", cur_test, i, frames_q[i]);
        errors++;
      end
      j++;
    end
    check_val("overflow", {23'h0, n < n_burst}, {23'h0, overflow});
    n_rd = 0;
    for (i = 0; i < n; i++)
      if (frames_q[i][23])
        n_rd++;
    check_count("rd_valid pulses", n_rd, rd_q.size());
    k = 0;
    for (i = 0; i < n; i++) begin
      if (frames_q[i][23] && k < rd_q.size()) begin
        check_val("rd_data", {8'h00, used_resp_q[i][15:0]}, {8'h00, rd_q[k]});
        k++;
      end
    end
    end_test();

    start_test("resync_bad_stop");
    send_byte(8'($urandom()), 1'b1);
    repeat (30 * baud_div) @(posedge clk);  // Three byte times idle
    run_single(rand_word((($urandom() & 1) != 0) ? mems_pkg::op_read : mems_pkg::op_write));
    end_test();

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- testbench/mems_bridge_sva.sv
`timescale 1ns/1ps

// Protocol checks on the SPI pins and the queue handshake
module mems_bridge_sva (
  input logic clk,
  input logic rst,
  input logic sck,
  input logic mosi,
  input logic cs,
  input logic pop,
  input logic empty,
  input logic push,
  input logic full
);

  // No sck edges outside a frame
  sck_low_when_idle: assert property (@(posedge clk) disable iff (rst) cs |-> !sck)
    else $error("sck high while cs is high");

  // MOSI only moves on the falling edge
  mosi_stable_sck_high: assert property (@(posedge clk) disable iff (rst)
    sck |-> $stable(mosi))
    else $error("mosi changed while sck was high");

  pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("pop seen while the queue is empty");

  push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push seen while the queue is full");

endmodule

// SPI side, no push or full visible here
bind mems_spi_master mems_bridge_sva spi_sva_inst (
  .clk(clk), .rst(rst), .sck(sck), .mosi(mosi), .cs(cs),
  .pop(pop), .empty(empty), .push(1'b0), .full(1'b0)
);

// Queue side, bus tied idle
bind word_fifo mems_bridge_sva fifo_sva_inst (
  .clk(clk), .rst(rst), .sck(1'b0), .mosi(1'b0), .cs(1'b1),
  .pop(pop), .empty(empty), .push(push), .full(full)
);

//--- src/mems_bridge_top.sv
`timescale 1ns/1ps

// UART command bridge to a MEMS sensor over SPI
module mems_bridge_top #(
  parameter int BAUD_DIV   = 434,  // Clocks per UART bit
  parameter int FIFO_DEPTH = 8,    // Queued commands
  parameter int CLK_DIV    = 9     // sck period exponent
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        rx,
  output logic        sck,
  output logic        mosi,
  input  logic        miso,
  output logic        cs,        // Active low
  output logic [15:0] rd_data,
  output logic        rd_valid,
  output logic        overflow   // Sticky
);

  logic [7:0]          byte_data;
  logic                byte_valid;
  logic                push;
  mems_pkg::mems_cmd_t push_cmd;
  logic                full;
  logic                pop;
  mems_pkg::mems_cmd_t pop_cmd;
  logic                empty;

  uart_rx #(.BAUD_DIV(BAUD_DIV)) uart_rx_inst (
    .clk        (clk),
    .rst        (rst),
    .rx         (rx),
    .byte_data  (byte_data),
    .byte_valid (byte_valid)
  );

  cmd_assembler #(.BAUD_DIV(BAUD_DIV)) cmd_assembler_inst (
    .clk        (clk),
    .rst        (rst),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .full       (full),
    .push       (push),
    .push_cmd   (push_cmd),
    .overflow   (overflow)
  );

  word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) word_fifo_inst (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .push_cmd (push_cmd),
    .pop      (pop),
    .pop_cmd  (pop_cmd),
    .full     (full),
    .empty    (empty)
  );

  // Pulls commands off the queue with the pop and empty handshake
  mems_spi_master #(.CLK_DIV(CLK_DIV)) mems_spi_master_inst (
    .clk      (clk),
    .rst      (rst),
    .pop_cmd  (pop_cmd),
    .empty    (empty),
    .pop      (pop),
    .sck      (sck),
    .mosi     (mosi),
    .miso     (miso),
    .cs       (cs),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

endmodule

//--- src/mems_spi_master.sv
`timescale 1ns/1ps

// Mode-0 SPI master, one 24-bit command per cs frame
module mems_spi_master #(
  parameter int CLK_DIV = 9  // sck period is 2**CLK_DIV clocks
) (
  input  logic                clk,
  input  logic                rst,
  input  mems_pkg::mems_cmd_t pop_cmd,
  input  logic                empty,
  output logic                pop,
  output logic                sck,
  output logic                mosi,
  input  logic                miso,
  output logic                cs,
  output logic [15:0]         rd_data,
  output logic                rd_valid
);

  localparam int w = mems_pkg::cmd_word_w;
  localparam logic [CLK_DIV-1:0] div_last = '1;                             // sck falls here
  localparam logic [CLK_DIV-1:0] div_rise = {1'b0, {(CLK_DIV-1){1'b1}}};  // sck rises here
  localparam logic [4:0] bit_last = 5'(w - 1);

  mems_pkg::spi_state_e state;
  logic [CLK_DIV-1:0]   div_cnt;   // Position inside the current sck period
  logic [4:0]           bit_cnt;   // Bits sent in this frame
  logic [w-1:0]         shreg;     // Command out at the top, MISO in at the bottom
  logic                 miso_bit;  // MISO caught on the rising edge
  logic                 is_read;   // Frame carries an op_read

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mems_pkg::st_idle;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      pop      <= 1'b0;
      sck      <= 1'b0;
      mosi     <= 1'b0;
      cs       <= 1'b1;
      rd_valid <= 1'b0;
      is_read  <= 1'b0;
    end else begin
      pop      <= 1'b0;  // Both strobes are single cycle
      rd_valid <= 1'b0;
      case (state)
        mems_pkg::st_idle: begin
          if (!empty) begin
            pop     <= 1'b1;  // Head leaves the queue at the next edge
            cs      <= 1'b0;  // Falls together with pop
            mosi    <= pop_cmd[w-1];  // MSB ready before the first rising edge
            is_read <= (pop_cmd.op == mems_pkg::op_read);
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= mems_pkg::st_shift;
          end
        end

        mems_pkg::st_shift: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == div_rise) begin
            sck <= 1'b1;  // Sensor samples mosi here
          end else if (div_cnt == div_last) begin
            sck <= 1'b0;
            if (bit_cnt == bit_last) begin
              // Half a period after the last rising edge
              cs    <= 1'b1;
              mosi  <= 1'b0;
              state <= mems_pkg::st_gap;
            end else begin
              mosi    <= shreg[w-2];  // Next bit after this edge's shift
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end

        mems_pkg::st_gap: begin
          div_cnt <= div_cnt + 1'b1;  // Wrapped to zero at frame end
          if (div_cnt == '0)
            rd_valid <= is_read;  // Cycle after cs rises
          if (div_cnt == div_last)
            state <= mems_pkg::st_idle;  // Full sck period with cs high
        end

        default: begin
          state <= mems_pkg::st_idle;
          cs    <= 1'b1;
          sck   <= 1'b0;
        end
      endcase
    end
  end

  // Datapath: load, sample on rise, shift on fall
  always_ff @(posedge clk) begin
    if (state == mems_pkg::st_idle && !empty)
      shreg <= pop_cmd;
    if (state == mems_pkg::st_shift && div_cnt == div_rise)
      miso_bit <= miso;
    if (state == mems_pkg::st_shift && div_cnt == div_last)
      shreg <= {shreg[w-2:0], miso_bit};
    if (state == mems_pkg::st_gap && div_cnt == '0)
      rd_data <= shreg[15:0];  // Last 16 bits seen on MISO
  end

endmodule

//--- src/word_fifo.sv
`timescale 1ns/1ps

// Command queue, first word falls through to pop_cmd
module word_fifo #(
  parameter int FIFO_DEPTH = 8  // Power of two
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  mems_pkg::mems_cmd_t push_cmd,
  input  logic                pop,
  output mems_pkg::mems_cmd_t pop_cmd,
  output logic                full,
  output logic                empty
);

  localparam int aw = $clog2(FIFO_DEPTH);

  mems_pkg::mems_cmd_t mem [FIFO_DEPTH];
  logic [aw:0]         wr_ptr;  // Extra MSB tells full from empty
  logic [aw:0]         rd_ptr;
  logic                do_push;
  logic                do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

  // A push into a full queue is fine when the head leaves the same cycle
  assign do_push = push && (!full || pop);
  assign do_pop  = pop && !empty;

  assign pop_cmd = mem[rd_ptr[aw-1:0]];  // Valid whenever empty is low

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr[aw-1:0]] <= push_cmd;
  end

endmodule

//--- src/cmd_assembler.sv
`timescale 1ns/1ps

// Builds 24-bit commands from three bytes, MSB byte first
module cmd_assembler #(
  parameter int BAUD_DIV = 434  // Clocks per UART bit, sets the idle timeout
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [7:0]          byte_data,
  input  logic                byte_valid,
  input  logic                full,
  output logic                push,
  output mems_pkg::mems_cmd_t push_cmd,
  output logic                overflow
);

  // Two byte times of silence drops a partial word
  localparam int idle_limit = 20 * BAUD_DIV;
  localparam int idle_w     = $clog2(idle_limit + 1);

  logic [mems_pkg::cmd_word_w-1:0] acc;       // Byte accumulator
  logic [1:0]                      byte_cnt;  // Bytes held so far, 0..2
  logic [idle_w-1:0]               idle_cnt;  // Clocks since the last byte
  logic                            timeout;

  assign timeout  = (idle_cnt == idle_w'(idle_limit));
  assign push_cmd = mems_pkg::mems_cmd_t'(acc);  // Whole word is in acc while push is high

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt <= '0;
      idle_cnt <= '0;
      push     <= 1'b0;
      overflow <= 1'b0;
    end else begin
      push <= 1'b0;
      if (byte_valid) begin
        idle_cnt <= '0;
        if (byte_cnt == 2'd2) begin
          byte_cnt <= '0;
          // Queue only shrinks until our push, so full cannot rise in between
          if (full)
            overflow <= 1'b1;  // Sticky until reset
          else
            push <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end else if (byte_cnt != 2'd0) begin
        if (timeout) begin
          byte_cnt <= '0;  // Resync, next byte starts a new word
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // Shift in each byte at the bottom
  always_ff @(posedge clk) begin
    if (byte_valid)
      acc <= {acc[mems_pkg::cmd_word_w-9:0], byte_data};
  end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps

// 8N1 receiver, LSB first, one-cycle byte_valid pulse
module uart_rx #(
  parameter int BAUD_DIV = 434  // Clocks per bit
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] byte_data,
  output logic       byte_valid
);

  localparam int cnt_w = $clog2(BAUD_DIV);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(BAUD_DIV - 1);      // Full bit reload
  localparam logic [cnt_w-1:0] bit_half = cnt_w'(BAUD_DIV / 2 - 1);  // Edge to mid-bit

  logic             rx_meta;   // First synchronizer stage
  logic             rx_sync;   // Safe to use
  logic             rx_last;   // For falling edge detect
  logic             busy;      // Inside a character
  logic [cnt_w-1:0] baud_cnt;  // Counts down to the next sample point
  logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
  logic [7:0]       shift;     // Data bits, LSB arrives first
  logic             sample;    // Mid-bit strobe

  assign sample = busy && (baud_cnt == '0);

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;  // Pulse only
      if (!busy) begin
        // Falling edge only, so a low stop bit cannot retrigger
        if (rx_last && !rx_sync) begin
          busy     <= 1'b1;
          baud_cnt <= bit_half;
          bit_idx  <= '0;
        end
      end else if (!sample) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= bit_last;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == 4'd0) begin
          if (rx_sync)
            busy <= 1'b0;  // Start bit gone high again, just a glitch
        end else if (bit_idx == 4'd9) begin
          busy       <= 1'b0;
          byte_valid <= rx_sync;  // Bad stop bit, byte silently dropped
        end
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (sample && (bit_idx != 4'd0) && (bit_idx != 4'd9))
      shift <= {rx_sync, shift[7:1]};
    if (sample && (bit_idx == 4'd9))
      byte_data <= shift;
  end

endmodule

//--- src/mems_pkg.sv
// Shared types for the sensor-configuration bridge
package mems_pkg;

  // Width of one sensor command as sent in a single SPI frame
  parameter int cmd_word_w = 24;

  // Bit 23 of the command word; MEMS convention is top bit set for a read
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } mems_op_e;

  // Command word as it sits in the queue and on the wire, MSB first
  typedef struct packed {
    mems_op_e    op;    // Read or write
    logic [6:0]  addr;  // Sensor register address
    logic [15:0] data;  // Write payload, don't care for reads
  } mems_cmd_t;

  // SPI master FSM
  typedef enum logic [1:0] {
    st_idle  = 2'd0,  // Waiting for a queued command
    st_shift = 2'd1,  // Frame in progress, cs low
    st_gap   = 2'd2   // cs high for one sck period between frames
  } spi_state_e;

endpackage
